// File: source/feeder_pkg.sv
package feeder_pkg;

    // ########################################################################
    // widths
    // ########################################################################
    localparam int XLEN           = 32;
    localparam int DATA_WIDTH_DEF = 16;
    localparam int ADDR_BITS_DEF  = 15;
    localparam int ACLEN          = 8;

    // one dram line, delivered as two halves
    localparam int LINE_BITS      = 512;
    localparam int LINE_BYTES     = LINE_BITS / 8;
    localparam int HALF_LINE_BITS = LINE_BITS / 2;

    // ########################################################################
    // device-bus register map
    // ########################################################################
    localparam logic [XLEN-1:0] REG_TPU_CMD     = 32'hC400_0000;
    localparam logic [XLEN-1:0] REG_PARAM_1     = 32'hC400_0004;
    localparam logic [XLEN-1:0] REG_PARAM_2     = 32'hC400_0008;
    localparam logic [XLEN-1:0] REG_BUSY        = 32'hC400_0020;
    localparam logic [XLEN-1:0] REG_RD_ADDR     = 32'hC400_2024;
    localparam logic [XLEN-1:0] REG_RD_LENGTH   = 32'hC400_2028;
    localparam logic [XLEN-1:0] REG_START       = 32'hC400_2030;
    localparam logic [XLEN-1:0] REG_SRAM_OFFSET = 32'hC400_2034;
    localparam logic [XLEN-1:0] REG_DATA_TYPE   = 32'hC400_2038;

    // accelerator load commands
    localparam logic [ACLEN-1:0] CMD_LOAD_INPUT  = 8'd9;
    localparam logic [ACLEN-1:0] CMD_LOAD_WEIGHT = 8'd10;

    // one command on the accelerator port
    typedef struct packed {
        logic [ACLEN-1:0]          cmd;
        logic [DATA_WIDTH_DEF-1:0] param_1;
        logic [DATA_WIDTH_DEF-1:0] param_2;
    } tpu_cmd_t;

endpackage

// File: source/feeder_cfg_if.sv
`timescale 1ns/1ps

interface feeder_cfg_if import feeder_pkg::*; #(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF,
    parameter int ADDR_BITS  = ADDR_BITS_DEF
);
    // bytes per accelerator word, the requester steps lines with it
    localparam int WORD_BYTES = DATA_WIDTH / 8;

    logic                 start;
    logic [XLEN-1:0]      rd_addr;
    logic [ADDR_BITS-1:0] rd_length;
    logic                 weight_sel;
    logic                 offset_clear;
    logic                 host_cmd_valid;
    tpu_cmd_t             host_cmd;

    modport regs (
        output start, rd_addr, rd_length, weight_sel,
        output offset_clear, host_cmd_valid, host_cmd
    );

    modport engine (
        input start, rd_addr, rd_length, weight_sel,
        input offset_clear, host_cmd_valid, host_cmd
    );

endinterface

// File: source/feeder_regs.sv
`timescale 1ns/1ps

module feeder_regs import feeder_pkg::*; #(
    parameter int ADDR_BITS = ADDR_BITS_DEF
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            strobe_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] wdata_i,
    input  logic            rw_i,
    input  logic            req_busy_i,
    input  logic            stream_busy_i,
    output logic            ready_o,
    output logic [XLEN-1:0] rdata_o,
    feeder_cfg_if.regs      cfg
);

    logic wr_en;
    logic rd_en;
    logic busy;

    // rw_i high marks a write
    assign wr_en = strobe_i & rw_i;
    assign rd_en = strobe_i & ~rw_i;

    // start counts too, the engines leave idle one cycle after it
    assign busy = req_busy_i | stream_busy_i | cfg.start;

    // ########################################################################
    // bus handshake and readback
    // ########################################################################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ready_o <= 1'b0;
        end else begin
            ready_o <= strobe_i;
        end
    end

    // other addresses leave the last value in place
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rdata_o <= '0;
        end else if (rd_en && addr_i == REG_BUSY) begin
            rdata_o <= {{(XLEN-1){1'b0}}, busy};
        end
    end

    // ########################################################################
    // pulses and settings
    // ########################################################################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cfg.start          <= 1'b0;
            cfg.offset_clear   <= 1'b0;
            cfg.host_cmd_valid <= 1'b0;
        end else begin
            cfg.start          <= wr_en && addr_i == REG_START;
            cfg.offset_clear   <= wr_en && addr_i == REG_SRAM_OFFSET;
            cfg.host_cmd_valid <= wr_en && addr_i == REG_TPU_CMD;
        end
    end

    // 0 loads the input buffer, 1 the weight buffer
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cfg.weight_sel <= 1'b0;
        end else if (wr_en && addr_i == REG_DATA_TYPE) begin
            cfg.weight_sel <= wdata_i[0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            case (addr_i)
                REG_RD_ADDR:   cfg.rd_addr          <= wdata_i;
                REG_RD_LENGTH: cfg.rd_length        <= wdata_i[ADDR_BITS-1:0];
                REG_TPU_CMD:   cfg.host_cmd.cmd     <= wdata_i[ACLEN-1:0];
                REG_PARAM_1:   cfg.host_cmd.param_1 <= wdata_i[DATA_WIDTH_DEF-1:0];
                REG_PARAM_2:   cfg.host_cmd.param_2 <= wdata_i[DATA_WIDTH_DEF-1:0];
                default: ;
            endcase
        end
    end

endmodule

// File: source/line_requester.sv
`timescale 1ns/1ps

module line_requester import feeder_pkg::*; #(
    parameter int ADDR_BITS = ADDR_BITS_DEF
) (
    input  logic            clk_i,
    input  logic            rst_i,
    feeder_cfg_if.engine    cfg,
    input  logic            addr_fifo_full_i,
    output logic            req_valid_o,
    output logic [XLEN-1:0] req_addr_o,
    output logic            busy_o
);

    localparam int OFF_BITS = $clog2(LINE_BYTES);

    typedef enum logic [1:0] {IDLE_S, WAIT_S, SEND_S} state_t;

    state_t               state_q;
    state_t               state_d;
    logic [XLEN-1:0]      addr_q;
    logic [ADDR_BITS-1:0] covered_q;
    logic [OFF_BITS:0]    line_left;
    logic [ADDR_BITS-1:0] line_words;
    logic [ADDR_BITS:0]   covered_next;
    logic                 last_req;

    // bytes and words from the current address to the line end
    assign line_left    = (OFF_BITS+1)'(LINE_BYTES) - {1'b0, addr_q[OFF_BITS-1:0]};
    assign line_words   = ADDR_BITS'(line_left / cfg.WORD_BYTES);
    assign covered_next = {1'b0, covered_q} + {1'b0, line_words};
    assign last_req     = covered_next >= {1'b0, cfg.rd_length};

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE_S: if (cfg.start) state_d = WAIT_S;
            WAIT_S: if (!addr_fifo_full_i) state_d = SEND_S;
            SEND_S: state_d = last_req ? IDLE_S : WAIT_S;
            default: state_d = IDLE_S;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= IDLE_S;
            covered_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE_S && cfg.start) begin
                covered_q <= '0;
            end else if (state_q == SEND_S) begin
                covered_q <= covered_next[ADDR_BITS-1:0];
            end
        end
    end

    // first request may be unaligned, the rest sit on line boundaries
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE_S && cfg.start) begin
            addr_q <= cfg.rd_addr;
        end else if (state_q == SEND_S) begin
            addr_q <= addr_q + XLEN'(line_left);
        end
    end

    assign req_valid_o = state_q == SEND_S;
    assign req_addr_o  = addr_q;
    assign busy_o      = state_q != IDLE_S;

endmodule

// File: source/word_streamer.sv
`timescale 1ns/1ps

module word_streamer import feeder_pkg::*; #(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF,
    parameter int ADDR_BITS  = ADDR_BITS_DEF
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    feeder_cfg_if.engine              cfg,
    input  logic                      data_fifo_empty_i,
    input  logic [HALF_LINE_BITS-1:0] line_data_h_i,
    input  logic [HALF_LINE_BITS-1:0] line_data_l_i,
    output logic                      data_fifo_rd_en_o,
    output logic                      cmd_valid_o,
    output tpu_cmd_t                  cmd_o,
    output logic                      busy_o
);

    localparam int WORDS      = LINE_BITS / DATA_WIDTH;
    localparam int PTR_BITS   = $clog2(WORDS);
    localparam int WORD_BYTES = DATA_WIDTH / 8;
    localparam int OFF_BITS   = $clog2(LINE_BYTES);

    typedef enum logic [1:0] {IDLE_S, WAIT_DATA_S, STREAM_S, POP_S} state_t;

    state_t                state_q;
    state_t                state_d;
    logic [LINE_BITS-1:0]  line_q;
    logic [PTR_BITS-1:0]   ptr_q;
    logic [ADDR_BITS-1:0]  sent_q;
    logic [ADDR_BITS-1:0]  index_q;
    logic [DATA_WIDTH-1:0] word;
    logic                  line_end;
    logic                  last_word;
    logic                  stream_valid_q;
    tpu_cmd_t              stream_cmd_q;

    assign word      = line_q[ptr_q*DATA_WIDTH +: DATA_WIDTH];
    assign line_end  = ptr_q == PTR_BITS'(WORDS - 1);
    assign last_word = sent_q + ADDR_BITS'(1) == cfg.rd_length;

    // ########################################################################
    // control
    // ########################################################################
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE_S:      if (cfg.start) state_d = WAIT_DATA_S;
            WAIT_DATA_S: if (!data_fifo_empty_i) state_d = STREAM_S;
            STREAM_S:    if (line_end || last_word) state_d = POP_S;
            POP_S:       state_d = (sent_q == cfg.rd_length) ? IDLE_S : WAIT_DATA_S;
            default:     state_d = IDLE_S;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE_S;
            ptr_q   <= '0;
            sent_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE_S && cfg.start) begin
                // unaligned start skips the leading words of the first line
                ptr_q  <= PTR_BITS'(cfg.rd_addr[OFF_BITS-1:0] / WORD_BYTES);
                sent_q <= '0;
            end else if (state_q == STREAM_S) begin
                ptr_q  <= ptr_q + PTR_BITS'(1);
                sent_q <= sent_q + ADDR_BITS'(1);
            end
        end
    end

    // buffer index runs on across transfers
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            index_q <= '0;
        end else if (cfg.offset_clear) begin
            index_q <= '0;
        end else if (state_q == STREAM_S) begin
            index_q <= index_q + ADDR_BITS'(1);
        end
    end

    // ########################################################################
    // datapath
    // ########################################################################
    always_ff @(posedge clk_i) begin
        if (state_q == WAIT_DATA_S && !data_fifo_empty_i) begin
            line_q <= {line_data_h_i, line_data_l_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stream_valid_q <= 1'b0;
        end else begin
            stream_valid_q <= state_q == STREAM_S;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == STREAM_S) begin
            stream_cmd_q.cmd     <= cfg.weight_sel ? CMD_LOAD_WEIGHT : CMD_LOAD_INPUT;
            stream_cmd_q.param_1 <= DATA_WIDTH_DEF'(word);
            stream_cmd_q.param_2 <= DATA_WIDTH_DEF'(index_q);
        end
    end

    // host command takes the port over a stream command
    assign cmd_valid_o = cfg.host_cmd_valid | stream_valid_q;
    assign cmd_o       = cfg.host_cmd_valid ? cfg.host_cmd : stream_cmd_q;

    assign data_fifo_rd_en_o = state_q == POP_S;
    assign busy_o            = state_q != IDLE_S;

endmodule

// File: source/data_feeder.sv
`timescale 1ns/1ps

module data_feeder import feeder_pkg::*; #(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF,
    parameter int ADDR_BITS  = ADDR_BITS_DEF
) (
    input  logic                      clk_i,
    input  logic                      rst_i,

    // device bus
    input  logic                      strobe_i,
    input  logic [XLEN-1:0]           addr_i,
    input  logic [XLEN-1:0]           wdata_i,
    input  logic                      rw_i,
    output logic                      ready_o,
    output logic [XLEN-1:0]           rdata_o,

    // address fifo toward dram
    input  logic                      addr_fifo_full_i,
    output logic                      req_valid_o,
    output logic [XLEN-1:0]           req_addr_o,

    // data fifo from dram
    input  logic                      data_fifo_empty_i,
    input  logic [HALF_LINE_BITS-1:0] line_data_h_i,
    input  logic [HALF_LINE_BITS-1:0] line_data_l_i,
    output logic                      data_fifo_rd_en_o,

    // accelerator command port
    output logic                      cmd_valid_o,
    output logic [ACLEN-1:0]          cmd_o,
    output logic [DATA_WIDTH-1:0]     param_1_o,
    output logic [DATA_WIDTH-1:0]     param_2_o
);

    logic     req_busy;
    logic     stream_busy;
    tpu_cmd_t acc_cmd;

    feeder_cfg_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_BITS(ADDR_BITS)) cfg_if ();

    feeder_regs #(.ADDR_BITS(ADDR_BITS)) i_regs (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .strobe_i      (strobe_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .rw_i          (rw_i),
        .req_busy_i    (req_busy),
        .stream_busy_i (stream_busy),
        .ready_o       (ready_o),
        .rdata_o       (rdata_o),
        .cfg           (cfg_if.regs)
    );

    line_requester #(.ADDR_BITS(ADDR_BITS)) i_requester (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .cfg              (cfg_if.engine),
        .addr_fifo_full_i (addr_fifo_full_i),
        .req_valid_o      (req_valid_o),
        .req_addr_o       (req_addr_o),
        .busy_o           (req_busy)
    );

    word_streamer #(.DATA_WIDTH(DATA_WIDTH), .ADDR_BITS(ADDR_BITS)) i_streamer (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .cfg               (cfg_if.engine),
        .data_fifo_empty_i (data_fifo_empty_i),
        .line_data_h_i     (line_data_h_i),
        .line_data_l_i     (line_data_l_i),
        .data_fifo_rd_en_o (data_fifo_rd_en_o),
        .cmd_valid_o       (cmd_valid_o),
        .cmd_o             (acc_cmd),
        .busy_o            (stream_busy)
    );

    // split the command struct onto the accelerator port
    assign cmd_o     = acc_cmd.cmd;
    assign param_1_o = DATA_WIDTH'(acc_cmd.param_1);
    assign param_2_o = DATA_WIDTH'(acc_cmd.param_2);

endmodule

// File: tb/data_feeder_tb.sv
`timescale 1ns/1ps

module data_feeder_tb import feeder_pkg::*; ();

    localparam logic [15:0] LFSR_SEED  = 16'd62571;
    localparam int          STIM_DEPTH = 64;

    logic                      clk_i;
    logic                      rst_i;
    logic                      strobe_i;
    logic [XLEN-1:0]           addr_i;
    logic [XLEN-1:0]           wdata_i;
    logic                      rw_i;
    logic                      ready_o;
    logic [XLEN-1:0]           rdata_o;
    logic                      addr_fifo_full_i = 1'b0;
    logic                      req_valid_o;
    logic [XLEN-1:0]           req_addr_o;
    logic                      data_fifo_empty_i = 1'b1;
    logic [HALF_LINE_BITS-1:0] line_data_h_i = '0;
    logic [HALF_LINE_BITS-1:0] line_data_l_i = '0;
    logic                      data_fifo_rd_en_o;
    logic                      cmd_valid_o;
    logic [7:0]                cmd_o;
    logic [15:0]               param_1_o;
    logic [15:0]               param_2_o;

    int          errors = 0;
    int          checks = 0;
    logic [71:0] stim_mem [0:STIM_DEPTH-1];
    logic        stim_ready = 1'b0;
    int          total_words = 0;

    // bus side expectations
    logic        strobe_q = 1'b0;
    logic        host_due_q = 1'b0;
    logic [7:0]  host_cmd_sh = '0;
    logic [15:0] param1_sh = '0;
    logic [15:0] param2_sh = '0;

    // transfer expectations
    logic [7:0]           stream_code = 8'd9;
    logic [31:0]          stream_addr = '0;
    int                   stream_left = 0;
    logic [15:0]          stream_index = '0;
    logic [LINE_BITS-1:0] line_exp;
    logic [31:0]          req_exp_addr = '0;
    int                   req_left = 0;
    int                   pops = 0;
    logic [31:0]          pending [$];
    int                   delay_cnt = 0;
    logic [15:0]          rng_state = LFSR_SEED;

    data_feeder i_data_feeder (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .strobe_i          (strobe_i),
        .addr_i            (addr_i),
        .wdata_i           (wdata_i),
        .rw_i              (rw_i),
        .ready_o           (ready_o),
        .rdata_o           (rdata_o),
        .addr_fifo_full_i  (addr_fifo_full_i),
        .req_valid_o       (req_valid_o),
        .req_addr_o        (req_addr_o),
        .data_fifo_empty_i (data_fifo_empty_i),
        .line_data_h_i     (line_data_h_i),
        .line_data_l_i     (line_data_l_i),
        .data_fifo_rd_en_o (data_fifo_rd_en_o),
        .cmd_valid_o       (cmd_valid_o),
        .cmd_o             (cmd_o),
        .param_1_o         (param_1_o),
        .param_2_o         (param_2_o)
    );

    // ########################################################################
    // helpers
    // ########################################################################
    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic expect_true(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR: %s", msg);
        end
    endtask

    // galois lfsr with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int rand_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(rng_state[0]);
            rng_state = lfsr_step(rng_state);
        end
        return value;
    endfunction

    // line contents from a seed offset by the line number
    function automatic logic [LINE_BITS-1:0] make_line(input logic [31:0] line_addr);
        logic [15:0]          s;
        logic [LINE_BITS-1:0] bits;
        s = LFSR_SEED + line_addr[21:6];
        if (s == 16'd0) begin
            s = LFSR_SEED;
        end
        for (int i = 0; i < LINE_BITS; i++) begin
            bits[i] = s[0];
            s = lfsr_step(s);
        end
        return bits;
    endfunction

    task automatic bus_access(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge clk_i);
        strobe_i = 1'b1;
        rw_i     = write;
        addr_i   = addr;
        wdata_i  = wdata;
        if (write) begin
            case (addr)
                REG_PARAM_1:     param1_sh = wdata[15:0];
                REG_PARAM_2:     param2_sh = wdata[15:0];
                REG_TPU_CMD:     host_cmd_sh = wdata[7:0];
                REG_SRAM_OFFSET: stream_index = '0;
                default: ;
            endcase
        end
        @(negedge clk_i);
        strobe_i = 1'b0;
        rdata    = rdata_o;
    endtask

    // start strobe with a busy read strobe in the very next cycle
    task automatic start_and_read_busy(output logic [31:0] rdata);
        @(negedge clk_i);
        strobe_i = 1'b1;
        rw_i     = 1'b1;
        addr_i   = REG_START;
        wdata_i  = 32'd0;
        @(negedge clk_i);
        rw_i     = 1'b0;
        addr_i   = REG_BUSY;
        @(negedge clk_i);
        strobe_i = 1'b0;
        rdata    = rdata_o;
    endtask

    // program, start, then poll busy until both engines are idle
    task automatic run_transfer(input logic [31:0] start_addr, input logic [31:0] info);
        logic [31:0] a;
        logic [31:0] rdata;
        int          len;
        int          covered;
        int          lines;
        len     = int'(info[14:0]);
        a       = start_addr;
        covered = 0;
        lines   = 0;
        while (covered < len) begin
            covered = covered + (64 - int'(a[5:0])) / 2;
            a       = (a | 32'h3F) + 32'd1;
            lines   = lines + 1;
        end
        bus_access(1'b1, REG_DATA_TYPE, {31'b0, info[16]}, rdata);
        bus_access(1'b1, REG_RD_ADDR, start_addr, rdata);
        bus_access(1'b1, REG_RD_LENGTH, {17'b0, info[14:0]}, rdata);
        stream_code  = info[16] ? 8'd10 : 8'd9;
        stream_addr  = start_addr;
        stream_left  = len;
        req_exp_addr = start_addr;
        req_left     = lines;
        pops         = 0;
        start_and_read_busy(rdata);
        compare_value("busy after start", 32'd1, rdata);
        bus_access(1'b0, REG_PARAM_1, 32'd0, rdata);
        compare_value("busy readback held", 32'd1, rdata);
        do begin
            bus_access(1'b0, REG_BUSY, 32'd0, rdata);
        end while (rdata != 32'd0);
        compare_value("commands left at idle", 32'd0, stream_left);
        compare_value("requests left at idle", 32'd0, req_left);
        compare_value("lines popped", lines, pops);
        compare_value("lines still pending", 32'd0, pending.size());
    endtask

    // ########################################################################
    // clock, monitors and dram model
    // ########################################################################
    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        strobe_q   <= strobe_i;
        host_due_q <= strobe_i && rw_i && addr_i == REG_TPU_CMD;
    end

    always @(negedge clk_i) begin
        if (!rst_i) begin
            compare_value("ready pulse", {31'b0, strobe_q}, {31'b0, ready_o});
            if (host_due_q) begin
                expect_true(cmd_valid_o, "host command did not reach the command port");
                compare_value("host cmd", {24'b0, host_cmd_sh}, {24'b0, cmd_o});
                compare_value("host param_1", {16'b0, param1_sh}, {16'b0, param_1_o});
                compare_value("host param_2", {16'b0, param2_sh}, {16'b0, param_2_o});
            end else if (cmd_valid_o) begin
                expect_true(stream_left > 0, "command issued with no word left to send");
                if (stream_left > 0) begin
                    line_exp = make_line(stream_addr & ~32'h3F);
                    compare_value("stream cmd", {24'b0, stream_code}, {24'b0, cmd_o});
                    compare_value("stream word",
                        {16'b0, line_exp[stream_addr[5:1]*16 +: 16]},
                        {16'b0, param_1_o});
                    compare_value("stream index", {16'b0, stream_index}, {16'b0, param_2_o});
                    stream_addr  = stream_addr + 32'd2;
                    stream_left  = stream_left - 1;
                    stream_index = stream_index + 16'd1;
                end
            end
        end
    end

    // full only changes while no request is out
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (req_valid_o) begin
                expect_true(!addr_fifo_full_i, "read request issued while the FIFO was full");
                expect_true(req_left > 0, "read request beyond the end of the transfer");
                compare_value("request address", req_exp_addr, req_addr_o);
                pending.push_back(req_addr_o);
                req_left     = req_left - 1;
                req_exp_addr = (req_exp_addr | 32'h3F) + 32'd1;
            end else begin
                addr_fifo_full_i = rand_bits(2) == 0;
            end
            if (data_fifo_rd_en_o) begin
                expect_true(!data_fifo_empty_i, "data FIFO popped while empty");
                if (!data_fifo_empty_i && pending.size() > 0) begin
                    void'(pending.pop_front());
                    pops              = pops + 1;
                    data_fifo_empty_i = 1'b1;
                    delay_cnt         = rand_bits(3);
                end
            end else if (data_fifo_empty_i && pending.size() > 0) begin
                if (delay_cnt == 0) begin
                    {line_data_h_i, line_data_l_i} = make_line(pending[0] & ~32'h3F);
                    data_fifo_empty_i = 1'b0;
                end else begin
                    delay_cnt = delay_cnt - 1;
                end
            end
        end
    end

    // ########################################################################
    // stimulus and watchdog
    // ########################################################################
    initial begin
        int          idx;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rdata;
        strobe_i = 1'b0;
        rw_i     = 1'b0;
        addr_i   = '0;
        wdata_i  = '0;
        rst_i    = 1'b1;
        for (int i = 0; i < STIM_DEPTH; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh("tb/feeder_stim.txt", stim_mem);
        for (int i = 0; i < STIM_DEPTH; i++) begin
            if (stim_mem[i][71:64] == 8'h03) begin
                total_words = total_words + int'(stim_mem[i][14:0]);
            end
        end
        stim_ready = 1'b1;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        idx = 0;
        while (idx < STIM_DEPTH && stim_mem[idx][71:64] != 8'h00) begin
            {op, addr, data} = stim_mem[idx];
            case (op)
                8'h01: bus_access(1'b1, addr, data, rdata);
                8'h02: begin
                    bus_access(1'b0, addr, 32'd0, rdata);
                    compare_value($sformatf("read %h", addr), data, rdata);
                end
                8'h03: run_transfer(addr, data);
                default: expect_true(1'b0, "unknown opcode in the stimulus file");
            endcase
            idx = idx + 1;
        end
        repeat (4) @(negedge clk_i);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // 200 cycles per requested word plus fixed slack
    initial begin
        int limit;
        wait (stim_ready);
        limit = 200 * total_words + 2000;
        repeat (limit) @(posedge clk_i);
        $display("ERROR: watchdog expired after %0d cycles", limit);
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: tb/feeder_stim.txt
// one entry per step, 18 hex digits: op (2), bus address (8), data (8)
// op 01 bus write, 02 bus read against expected data, 03 transfer
// a transfer takes rd_addr from the address field, data bit 16 selects weights
// and data bits 14:0 give the word count
// idle busy readback
02C400002000000000
// host command with both parameters
01C400000400001234
01C40000080000BEEF
01C400000000000005
// clear the buffer index, then two transfers back to back
01C400203400000000
03000010260000003C
030000203200010028
// other addresses hold the last readback
02C400000400000000
// clear again, short transfer crossing one line boundary
01C400203400000000
030000303E00000005

// File: verilog.f
source/feeder_pkg.sv
source/feeder_cfg_if.sv
source/feeder_regs.sv
source/line_requester.sv
source/word_streamer.sv
source/data_feeder.sv
tb/data_feeder_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= data_feeder_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
